// File: mempool_l2_pkg.sv
// ******************************
// Geometry of the L2 path. Base addresses must be aligned to their window size
// The L2 is word interleaved over the banks, so the bank index sits above the byte offset
// ******************************

package mempool_l2_pkg;

  // Bus widths
  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned StrbWidth      = DataWidth / 8;
  localparam int unsigned ByteOffsetBits = $clog2(StrbWidth);

  // L2 SRAM, word interleaved over the banks
  localparam int unsigned NumL2Banks     = 4;
  localparam int unsigned L2BankIdxBits  = $clog2(NumL2Banks);
  localparam int unsigned L2BankNumWords = 256;
  localparam int unsigned L2RowBits      = $clog2(L2BankNumWords);
  localparam int unsigned L2Size         = NumL2Banks * L2BankNumWords * StrbWidth;

  // Boot ROM
  localparam int unsigned BootromNumWords = 16;
  localparam int unsigned BootromWordBits = $clog2(BootromNumWords);
  localparam int unsigned BootromSize     = BootromNumWords * StrbWidth;

  // Upper address bits that neither view decodes
  localparam int unsigned L2TagBits  = AddrWidth - L2RowBits - L2BankIdxBits - ByteOffsetBits;
  localparam int unsigned RomTagBits = AddrWidth - BootromWordBits - ByteOffsetBits;

  // Target of a request, chosen by the address window
  typedef enum logic [1:0] {
    RegionNone = 2'd0,
    RegionL2   = 2'd1,
    RegionRom  = 2'd2
  } l2_region_e;

  // The same request address, read as a banked L2 address or as a ROM word address
  typedef union packed {
    struct packed {
      logic [L2TagBits-1:0]      tag;
      logic [L2RowBits-1:0]      row;
      logic [L2BankIdxBits-1:0]  bank;
      logic [ByteOffsetBits-1:0] byte_off;
    } l2;
    struct packed {
      logic [RomTagBits-1:0]      tag;
      logic [BootromWordBits-1:0] word;
      logic [ByteOffsetBits-1:0]  byte_off;
    } rom;
  } l2_addr_u;

endpackage : mempool_l2_pkg

// File: l2_bank.sv
// ******************************
// Single-port SRAM bank, read data valid one cycle after req_i
// Contents are undefined until written
// ******************************

`timescale 1ns/100ps

module l2_bank (
  input  logic                                 clk_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [mempool_l2_pkg::L2RowBits-1:0] addr_i,
  input  logic [mempool_l2_pkg::DataWidth-1:0] wdata_i,
  input  logic [mempool_l2_pkg::StrbWidth-1:0] strb_i,
  output logic [mempool_l2_pkg::DataWidth-1:0] rdata_o
);

  logic [mempool_l2_pkg::DataWidth-1:0] mem [mempool_l2_pkg::L2BankNumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Byte lanes with a clear strobe keep their old value
        for (int unsigned i = 0; i < mempool_l2_pkg::StrbWidth; i++) begin
          if (strb_i[i]) begin
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

  a_addr_known : assert property (
    @(posedge clk_i) req_i |-> !$isunknown(addr_i)
  );

endmodule : l2_bank

// File: bootrom.sv
// ******************************
// Boot ROM loaded from bootrom.hex at start
// Read data valid one cycle after req_i
// ******************************

`timescale 1ns/100ps

module bootrom (
  input  logic                                       clk_i,
  input  logic                                       req_i,
  input  logic [mempool_l2_pkg::BootromWordBits-1:0] addr_i,
  output logic [mempool_l2_pkg::DataWidth-1:0]       rdata_o
);

  logic [mempool_l2_pkg::DataWidth-1:0] mem [mempool_l2_pkg::BootromNumWords];

  // One 32-bit hex word per line
  initial begin
    $readmemh("bootrom.hex", mem);
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule : bootrom

// File: l2_addr_decoder.sv
// ******************************
// Stage 1, one cycle of latency. The two windows must not overlap
// Addresses outside both windows are passed on as RegionNone
// ******************************

`timescale 1ns/100ps

module l2_addr_decoder #(
  parameter logic [mempool_l2_pkg::AddrWidth-1:0] L2BaseAddr      = 32'h8000_0000,
  parameter logic [mempool_l2_pkg::AddrWidth-1:0] BootromBaseAddr = 32'hA000_0000
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   req_i,
  input  logic                                   we_i,
  input  logic [mempool_l2_pkg::AddrWidth-1:0]   addr_i,
  input  logic [mempool_l2_pkg::DataWidth-1:0]   wdata_i,
  input  logic [mempool_l2_pkg::StrbWidth-1:0]   strb_i,
  output logic                                   valid_o,
  output mempool_l2_pkg::l2_region_e             region_o,
  output mempool_l2_pkg::l2_addr_u               addr_o,
  output logic                                   we_o,
  output logic [mempool_l2_pkg::DataWidth-1:0]   wdata_o,
  output logic [mempool_l2_pkg::StrbWidth-1:0]   strb_o
);

  // One extra bit so a window ending at the top of the map does not wrap
  localparam logic [mempool_l2_pkg::AddrWidth:0] L2EndAddr =
    {1'b0, L2BaseAddr} + mempool_l2_pkg::L2Size;
  localparam logic [mempool_l2_pkg::AddrWidth:0] BootromEndAddr =
    {1'b0, BootromBaseAddr} + mempool_l2_pkg::BootromSize;

  logic                       l2_hit;
  logic                       rom_hit;
  mempool_l2_pkg::l2_region_e region_d;

  // Base is inside the window, end is not
  assign l2_hit  = (addr_i >= L2BaseAddr) && ({1'b0, addr_i} < L2EndAddr);
  assign rom_hit = (addr_i >= BootromBaseAddr) && ({1'b0, addr_i} < BootromEndAddr);

  always_comb begin
    region_d = mempool_l2_pkg::RegionNone;
    if (l2_hit) begin
      region_d = mempool_l2_pkg::RegionL2;
    end else if (rom_hit) begin
      region_d = mempool_l2_pkg::RegionRom;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= req_i;
    end
  end

  // Payload only moves with a request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      region_o <= region_d;
      addr_o   <= addr_i;
      we_o     <= we_i;
      wdata_o  <= wdata_i;
      strb_o   <= strb_i;
    end
  end

  // Overlapping windows would make the region ambiguous
  a_windows_disjoint : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) req_i |-> !(l2_hit && rom_hit)
  );

endmodule : l2_addr_decoder

// File: l2_access_stage.sv
// ******************************
// Stage 2 adds one cycle of latency through the registered memory reads
// Every valid request gets a response the next cycle as there is no back-pressure
// ******************************

`timescale 1ns/100ps

module l2_access_stage (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 valid_i,
  input  mempool_l2_pkg::l2_region_e           region_i,
  input  mempool_l2_pkg::l2_addr_u             addr_i,
  input  logic                                 we_i,
  input  logic [mempool_l2_pkg::DataWidth-1:0] wdata_i,
  input  logic [mempool_l2_pkg::StrbWidth-1:0] strb_i,
  output logic                                 rvalid_o,
  output logic [mempool_l2_pkg::DataWidth-1:0] rdata_o,
  output logic                                 err_o
);

  logic                                                               l2_req;
  logic                                                               rom_req;
  logic                                                               err_d;
  logic [mempool_l2_pkg::NumL2Banks-1:0]                              bank_req;
  logic [mempool_l2_pkg::NumL2Banks-1:0][mempool_l2_pkg::DataWidth-1:0] bank_rdata;
  logic [mempool_l2_pkg::DataWidth-1:0]                               rom_rdata;

  // Response side state held one entry behind the request
  logic                                     err_q;
  logic                                     we_q;
  logic [mempool_l2_pkg::L2BankIdxBits-1:0] bank_q;
  mempool_l2_pkg::l2_region_e               region_q;

  assign l2_req  = valid_i && (region_i == mempool_l2_pkg::RegionL2);
  // ROM writes are dropped and flagged
  assign rom_req = valid_i && (region_i == mempool_l2_pkg::RegionRom) && !we_i;
  assign err_d   = valid_i && ((region_i == mempool_l2_pkg::RegionNone) ||
                               ((region_i == mempool_l2_pkg::RegionRom) && we_i));

  for (genvar b = 0; b < mempool_l2_pkg::NumL2Banks; b++) begin : gen_l2_banks
    // The bank is free every cycle and needs no grant
    assign bank_req[b] = l2_req && (addr_i.l2.bank == b);

    l2_bank i_l2_bank (
      .clk_i  (clk_i          ),
      .req_i  (bank_req[b]    ),
      .we_i   (we_i           ),
      .addr_i (addr_i.l2.row  ),
      .wdata_i(wdata_i        ),
      .strb_i (strb_i         ),
      .rdata_o(bank_rdata[b]  )
    );
  end

  bootrom i_bootrom (
    .clk_i  (clk_i          ),
    .req_i  (rom_req        ),
    .addr_i (addr_i.rom.word),
    .rdata_o(rom_rdata      )
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_o <= valid_i;
      err_q    <= err_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      region_q <= region_i;
      we_q     <= we_i;
      bank_q   <= addr_i.l2.bank;
    end
  end

  // Writes and errors answer with zero data
  always_comb begin
    rdata_o = '0;
    if (!we_q) begin
      if (region_q == mempool_l2_pkg::RegionL2) begin
        rdata_o = bank_rdata[bank_q];
      end else if (region_q == mempool_l2_pkg::RegionRom) begin
        rdata_o = rom_rdata;
      end
    end
  end

  assign err_o = err_q;

endmodule : l2_access_stage

// File: mempool_l2_system.sv
// ******************************
// L2 SRAM and boot ROM behind one word port, response 2 cycles after the request
// Out-of-window accesses and ROM writes complete with err_o
// ******************************

`timescale 1ns/100ps

module mempool_l2_system #(
  parameter logic [mempool_l2_pkg::AddrWidth-1:0] L2BaseAddr      = 32'h8000_0000,
  parameter logic [mempool_l2_pkg::AddrWidth-1:0] BootromBaseAddr = 32'hA000_0000
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [mempool_l2_pkg::AddrWidth-1:0] addr_i,
  input  logic [mempool_l2_pkg::DataWidth-1:0] wdata_i,
  input  logic [mempool_l2_pkg::StrbWidth-1:0] strb_i,
  output logic                                 rvalid_o,
  output logic [mempool_l2_pkg::DataWidth-1:0] rdata_o,
  output logic                                 err_o
);

  // Decoded request between the two stages
  logic                                 dec_valid;
  mempool_l2_pkg::l2_region_e           dec_region;
  mempool_l2_pkg::l2_addr_u             dec_addr;
  logic                                 dec_we;
  logic [mempool_l2_pkg::DataWidth-1:0] dec_wdata;
  logic [mempool_l2_pkg::StrbWidth-1:0] dec_strb;

  l2_addr_decoder #(
    .L2BaseAddr     (L2BaseAddr     ),
    .BootromBaseAddr(BootromBaseAddr)
  ) i_l2_addr_decoder (
    .clk_i   (clk_i     ),
    .rst_n_i (rst_n_i   ),
    .req_i   (req_i     ),
    .we_i    (we_i      ),
    .addr_i  (addr_i    ),
    .wdata_i (wdata_i   ),
    .strb_i  (strb_i    ),
    .valid_o (dec_valid ),
    .region_o(dec_region),
    .addr_o  (dec_addr  ),
    .we_o    (dec_we    ),
    .wdata_o (dec_wdata ),
    .strb_o  (dec_strb  )
  );

  l2_access_stage i_l2_access_stage (
    .clk_i   (clk_i     ),
    .rst_n_i (rst_n_i   ),
    .valid_i (dec_valid ),
    .region_i(dec_region),
    .addr_i  (dec_addr  ),
    .we_i    (dec_we    ),
    .wdata_i (dec_wdata ),
    .strb_i  (dec_strb  ),
    .rvalid_o(rvalid_o  ),
    .rdata_o (rdata_o   ),
    .err_o   (err_o     )
  );

endmodule : mempool_l2_system

// File: tb_mempool_l2_system.sv
// ******************************
// Expects bootrom.hex in the working directory and the default window bases
// Reads only aligned words, so the L2 model works on whole words
// ******************************

`timescale 1ns/100ps

module tb_mempool_l2_system;

  localparam logic [31:0] L2Base     = 32'h8000_0000;
  localparam logic [31:0] RomBase    = 32'hA000_0000;
  localparam int unsigned L2Bytes    = 4096;
  localparam int unsigned L2Words    = L2Bytes / 4;
  localparam int unsigned RomWords   = 16;
  localparam int unsigned NumPartial = 64;
  localparam int unsigned NumRandom  = 400;
  localparam int unsigned Seed       = 18;
  localparam int unsigned NumOps     = 3 * L2Words + 2 * NumPartial + 3 * RomWords + 12 + NumRandom;
  localparam int unsigned WatchdogNs = NumOps * 4 * 2 + 200;

  logic        clk_i;
  logic        rst_n_i;
  logic        req_i;
  logic        we_i;
  logic [31:0] addr_i;
  logic [31:0] wdata_i;
  logic [3:0]  strb_i;
  logic        rvalid_o;
  logic [31:0] rdata_o;
  logic        err_o;

  // Byte-exact L2 image and the expected ROM contents
  logic [7:0]  l2_model [L2Bytes];
  logic [31:0] rom_model [RomWords];
  logic [31:0] exp_rdata_q [$];
  logic        exp_err_q [$];
  int unsigned exp_cyc_q [$];
  int unsigned cyc = 0;
  int unsigned mismatch_count = 0;
  int unsigned other_count = 0;
  // First address past each window, and addresses just below and far outside
  logic [31:0] oow_addr [6] = '{32'h8000_1000, 32'hA000_0040, 32'h7FFF_FFFC,
                                32'h9FFF_FFFC, 32'h0000_0000, 32'hFFFF_FFFC};

  mempool_l2_system i_mempool_l2_system (
    .clk_i   (clk_i   ),
    .rst_n_i (rst_n_i ),
    .req_i   (req_i   ),
    .we_i    (we_i    ),
    .addr_i  (addr_i  ),
    .wdata_i (wdata_i ),
    .strb_i  (strb_i  ),
    .rvalid_o(rvalid_o),
    .rdata_o (rdata_o ),
    .err_o   (err_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  initial begin
    #(WatchdogNs);
    $display("Timeout: the run did not finish within %0d ns", WatchdogNs);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
  endfunction

  // Expected response of one request; L2 writes update the model
  function automatic void expected_response(input logic we, input logic [31:0] addr,
      input logic [31:0] wdata, input logic [3:0] strb,
      output logic [31:0] rdata, output logic err);
    logic [31:0] off;
    int          i;
    rdata = '0;
    err   = 1'b0;
    if (addr >= L2Base && addr < L2Base + L2Bytes) begin
      off = addr - L2Base;
      for (i = 0; i < 4; i++) begin
        if (we && strb[i]) l2_model[{off[11:2], i[1:0]}] = wdata[8*i +: 8];
        if (!we) rdata[8*i +: 8] = l2_model[{off[11:2], i[1:0]}];
      end
    end else if (addr >= RomBase && addr < RomBase + 4 * RomWords) begin
      off = addr - RomBase;
      if (we) err = 1'b1;
      else rdata = rom_model[off[5:2]];
    end else begin
      err = 1'b1;
    end
  endfunction

  task automatic send_request(input logic we, input logic [31:0] addr,
      input logic [31:0] wdata, input logic [3:0] strb);
    logic [31:0] exp_rdata;
    logic        exp_err;
    @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    strb_i  = strb;
    expected_response(we, addr, wdata, strb, exp_rdata, exp_err);
    exp_rdata_q.push_back(exp_rdata);
    exp_err_q.push_back(exp_err);
    exp_cyc_q.push_back(cyc);
  endtask

  // Stop requesting and wait a bounded time for the pipeline to empty
  task automatic finish_phase();
    int unsigned wait_cycles;
    @(negedge clk_i);
    req_i = 1'b0;
    we_i  = 1'b0;
    wait_cycles = 0;
    while (exp_cyc_q.size() != 0 && wait_cycles < 8) begin
      @(posedge clk_i);
      wait_cycles++;
    end
    if (exp_cyc_q.size() != 0) begin
      other_count++;
      $display("%0d responses still outstanding at %0t", exp_cyc_q.size(), $time);
    end
  endtask

  // A request driven in cycle n answers in cycle n + 2
  always @(negedge clk_i) begin : compare_responses
    logic [31:0] exp_rdata;
    logic        exp_err;
    int unsigned issue_cyc;
    if (rvalid_o) begin
      if (exp_cyc_q.size() == 0) begin
        other_count++;
        $display("Response with no request pending at %0t", $time);
      end else begin
        exp_rdata = exp_rdata_q.pop_front();
        exp_err   = exp_err_q.pop_front();
        issue_cyc = exp_cyc_q.pop_front();
        check_value("rdata_o", rdata_o, exp_rdata);
        check_value("err_o", {31'd0, err_o}, {31'd0, exp_err});
        if (cyc != issue_cyc + 2) begin
          other_count++;
          $display("Response for cycle %0d came in cycle %0d", issue_cyc, cyc);
        end
      end
    end else if (exp_cyc_q.size() != 0 && cyc > exp_cyc_q[0] + 2) begin
      other_count++;
      $display("No response for the request of cycle %0d", exp_cyc_q[0]);
      exp_rdata = exp_rdata_q.pop_front();
      exp_err   = exp_err_q.pop_front();
      issue_cyc = exp_cyc_q.pop_front();
    end
  end

  initial begin : stimulus
    int unsigned idx;
    int unsigned kind;
    logic [31:0] addr;
    void'($urandom(Seed));
    $readmemh("bootrom.hex", rom_model);
    rst_n_i = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    strb_i  = '0;
    repeat (5) begin
      @(negedge clk_i);
      check_value("rvalid_o", {31'd0, rvalid_o}, 32'd0);
    end
    rst_n_i = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      check_value("rvalid_o", {31'd0, rvalid_o}, 32'd0);
    end
    // Fill every L2 word, then read it all back
    for (idx = 0; idx < L2Words; idx++) send_request(1'b1, L2Base + (idx << 2),
                                                     fill_word(L2Base + (idx << 2)), 4'hF);
    for (idx = 0; idx < L2Words; idx++) send_request(1'b0, L2Base + (idx << 2), '0, '0);
    finish_phase();
    repeat (NumPartial) begin
      addr = L2Base + ($urandom_range(L2Words - 1, 0) << 2);
      send_request(1'b1, addr, $urandom(), 4'($urandom_range(15, 0)));
      send_request(1'b0, addr, '0, '0);
    end
    finish_phase();
    // ROM reads, rejected writes, then the same reads again
    for (idx = 0; idx < RomWords; idx++) send_request(1'b0, RomBase + (idx << 2), '0, '0);
    for (idx = 0; idx < RomWords; idx++) send_request(1'b1, RomBase + (idx << 2),
                                                      $urandom(), 4'hF);
    for (idx = 0; idx < RomWords; idx++) send_request(1'b0, RomBase + (idx << 2), '0, '0);
    finish_phase();
    for (idx = 0; idx < 6; idx++) begin
      send_request(1'b1, oow_addr[idx], $urandom(), 4'hF);
      send_request(1'b0, oow_addr[idx], '0, '0);
    end
    for (idx = 0; idx < L2Words; idx++) send_request(1'b0, L2Base + (idx << 2), '0, '0);
    finish_phase();
    repeat (NumRandom) begin
      kind = $urandom_range(9, 0);
      if (kind < 6) addr = L2Base + ($urandom_range(L2Words - 1, 0) << 2);
      else if (kind < 8) addr = RomBase + ($urandom_range(RomWords - 1, 0) << 2);
      else addr = $urandom() & 32'hFFFF_FFFC;
      send_request(1'($urandom_range(1, 0)), addr, $urandom(), 4'($urandom_range(15, 0)));
    end
    finish_phase();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_mempool_l2_system

// File: bootrom.hex
// One 32-bit ROM word per line, word 0 first
00000297
02028293
30529073
f1402573
00000593
00100613
00c5a023
0000006f
deadbeef
1badb002
c0ffee11
5a5a0f0f
0badf00d
7e57c0de
a5a5a5a5
feedface

// File: list.f
mempool_l2_pkg.sv
l2_bank.sv
bootrom.sv
l2_addr_decoder.sv
l2_access_stage.sv
mempool_l2_system.sv
tb_mempool_l2_system.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run with Verilator from the project root, then look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mempool_l2_system \
  -f list.f -o tb_sim || exit 1
sim_out="$(./obj_dir/tb_sim)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx 'SIMULATION PASSED' && exit 0 || exit 1
